// File: Makefile
# Verilator flow for the execute and writeback-commit subsystem
TOP := wbc_subsystem_tb

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level with the bound properties
lint:
	verilator --lint-only -Wall -Wno-fatal --assert --timing \
	  -f wbc_subsystem.f --top-module wbc_subsystem

# Build and run; a nonzero exit or the fail message in the log fails the run
sim:
	verilator --binary --assert --timing -Wno-fatal -j 0 \
	  -f wbc_subsystem.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	  if [ $$status -ne 0 ]; then exit 1; fi; \
	  if grep -qF '*** FAILED ***' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: rtl/exec_pipe.sv
/*
  Execute pipe: one-cycle add or iterative shift-and-add multiply,
  result held on a val/rdy channel until taken
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module exec_pipe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_val,
  output logic               req_rdy,
  input  wbc_pkg::exec_req_t req,
  output logic               xw_val,
  input  logic               xw_rdy,
  output wbc_pkg::xw_msg_t   xw
);
  import wbc_pkg::*;

  // Multiplier bits consumed per step
  localparam int STEP_BITS = (32 + `WBC_MUL_CYCLES - 1) / `WBC_MUL_CYCLES;
  localparam int CNT_BITS  = $clog2(`WBC_MUL_CYCLES + 1);

  logic                busy;
  logic [CNT_BITS-1:0] remaining;
  logic [31:0]         mcand;
  logic [31:0]         mplier;
  xw_msg_t             res;
  logic                accept;
  logic                running;
  logic [31:0]         src_acc;
  logic [31:0]         src_mcand;
  logic [31:0]         src_mplier;
  logic [31:0]         step_acc;

  // Partial products for one chunk of the multiplier
  function automatic logic [31:0] mul_step(input logic [31:0] acc_in,
                                           input logic [31:0] mcand_in,
                                           input logic [31:0] mplier_in);
    logic [31:0] sum;
    sum = acc_in;
    for (int k = 0; k < STEP_BITS; k++) begin
      if (mplier_in[k]) sum = sum + (mcand_in << k);
    end
    return sum;
  endfunction

  assign req_rdy = !busy;
  assign accept  = req_val && !busy;
  assign running = busy && (remaining != '0);
  assign xw_val  = busy && (remaining == '0);
  assign xw      = res;

  // First step runs on the accept edge, from the raw operands
  assign src_acc    = accept ? 32'd0 : res.wdata;
  assign src_mcand  = accept ? req.instr.a : mcand;
  assign src_mplier = accept ? req.instr.b : mplier;
  assign step_acc   = mul_step(src_acc, src_mcand, src_mplier);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      remaining <= '0;
    end else if (accept) begin
      busy      <= 1'b1;
      remaining <= (req.instr.op == OP_ADD) ? '0 : CNT_BITS'(`WBC_MUL_CYCLES - 1);
    end else if (running) begin
      remaining <= remaining - 1'b1;
    end else if (xw_val && xw_rdy) begin
      busy <= 1'b0;
    end
  end

  // Result word doubles as the multiply accumulator
  always_ff @(posedge clk) begin
    if (accept) begin
      res.pc      <= req.instr.pc;
      res.seq_num <= req.seq_num;
      res.waddr   <= req.instr.waddr;
      res.wen     <= req.instr.wen;
      res.wdata   <= (req.instr.op == OP_ADD) ? req.instr.a + req.instr.b : step_acc;
    end else if (running) begin
      res.wdata <= step_acc;
    end
    if (accept || running) begin
      mcand  <= src_mcand << STEP_BITS;
      mplier <= src_mplier >> STEP_BITS;
    end
  end

endmodule

`default_nettype wire

// File: rtl/issue_dispatch.sv
/*
  Issue stage: numbers instructions, limits the in-flight count
  and steers each one to the lowest-indexed idle execute pipe
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module issue_dispatch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_val,
  output logic                      in_rdy,
  input  wbc_pkg::instr_t           in_instr,
  output logic [`WBC_NUM_PIPES-1:0] req_val,
  input  logic [`WBC_NUM_PIPES-1:0] req_rdy,
  output wbc_pkg::exec_req_t        req [`WBC_NUM_PIPES],
  input  logic                      commit_pulse
);
  import wbc_pkg::*;

  localparam int CNT_W = `WBC_SEQ_BITS + 1;
  localparam logic [CNT_W-1:0] FULL = CNT_W'(`WBC_ROB_DEPTH);

  // Output register holding one numbered instruction
  logic                      hold_val;
  exec_req_t                 hold_req;
  seq_t                      seq_cnt;
  logic [CNT_W-1:0]          inflight;
  logic [`WBC_NUM_PIPES-1:0] grant;
  logic                      found;
  logic                      accept;
  logic                      taken;

  // ------------------------------------------------------------------
  // Input handshake
  // ------------------------------------------------------------------

  // Ready from state only, never from in_val
  assign in_rdy = !hold_val && (inflight != FULL);
  assign accept = in_val && in_rdy;

  // ------------------------------------------------------------------
  // Pipe steering
  // ------------------------------------------------------------------

  // Lowest-indexed idle pipe wins
  always_comb begin
    grant = '0;
    found = 1'b0;
    for (int i = 0; i < `WBC_NUM_PIPES; i++) begin
      if (hold_val && req_rdy[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  assign req_val = grant;
  assign taken   = |grant;

  // Same payload offered to every pipe, only one sees req_val
  always_comb begin
    for (int i = 0; i < `WBC_NUM_PIPES; i++) begin
      req[i] = hold_req;
    end
  end

  // ------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_val <= 1'b0;
      seq_cnt  <= '0;
      inflight <= '0;
    end else begin
      if (accept) begin
        hold_val <= 1'b1;
        seq_cnt  <= seq_cnt + 1'b1;
      end else if (taken) begin
        hold_val <= 1'b0;
      end
      // Credit up on accept, down on commit
      case ({accept, commit_pulse})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // Payload, tagged with the current sequence number
  always_ff @(posedge clk) begin
    if (accept) begin
      hold_req.instr   <= in_instr;
      hold_req.seq_num <= seq_cnt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/wbc_pkg.sv
/*
  Shared types: operation code, instruction, pipe request,
  execute-to-writeback, completion and commit messages
*/
`default_nettype none
`include "wbc_settings.svh"

package wbc_pkg;

  // Sequence number, wraps modulo the reorder buffer depth
  typedef logic [`WBC_SEQ_BITS-1:0] seq_t;

  typedef enum logic {
    OP_ADD = 1'b0,
    OP_MUL = 1'b1
  } op_e;

  // Instruction as it arrives, operands already read
  typedef struct packed {
    logic [31:0] pc;
    op_e         op;
    logic [4:0]  waddr;
    logic        wen;
    logic [31:0] a;
    logic [31:0] b;
  } instr_t;

  // Dispatch to pipe
  typedef struct packed {
    instr_t instr;
    seq_t   seq_num;
  } exec_req_t;

  // Pipe to writeback-commit
  typedef struct packed {
    logic [31:0] pc;
    seq_t        seq_num;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } xw_msg_t;

  // Completion strobe payload, no pc
  typedef struct packed {
    seq_t        seq_num;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } complete_msg_t;

  // Commit strobe payload, same fields as xw_msg_t
  typedef struct packed {
    logic [31:0] pc;
    seq_t        seq_num;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } commit_msg_t;

endpackage

`default_nettype wire

// File: rtl/wbc_settings.svh
/*
  Build-time sizing for the execute and writeback-commit subsystem
*/
`ifndef WBC_SETTINGS_SVH
`define WBC_SETTINGS_SVH

// Number of identical execute pipes
`define WBC_NUM_PIPES 2

// Sequence number width, sets reorder buffer depth and in-flight limit
`define WBC_SEQ_BITS 3

// Cycles a multiply holds a pipe
`define WBC_MUL_CYCLES 4

// Derived reorder buffer depth
`define WBC_ROB_DEPTH (1 << `WBC_SEQ_BITS)

`endif

// File: rtl/wbc_subsystem.sv
/*
  Top level: issue stage, generated execute pipes and the
  writeback-commit unit
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module wbc_subsystem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_val,
  output logic                   in_rdy,
  input  wbc_pkg::instr_t        in_instr,
  output logic                   complete_val,
  output wbc_pkg::complete_msg_t complete,
  output logic                   commit_val,
  output wbc_pkg::commit_msg_t   commit
);
  import wbc_pkg::*;

  // Dispatch to pipes
  logic [`WBC_NUM_PIPES-1:0] req_val;
  logic [`WBC_NUM_PIPES-1:0] req_rdy;
  exec_req_t                 req [`WBC_NUM_PIPES];

  // Pipes to writeback-commit
  logic [`WBC_NUM_PIPES-1:0] xw_val;
  logic [`WBC_NUM_PIPES-1:0] xw_rdy;
  xw_msg_t                   xw [`WBC_NUM_PIPES];

  // Commit strobe doubles as the in-flight credit return
  issue_dispatch u_issue_dispatch (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .in_instr     (in_instr),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req          (req),
    .commit_pulse (commit_val)
  );

  for (genvar i = 0; i < `WBC_NUM_PIPES; i++) begin : g_pipe
    exec_pipe u_exec_pipe (
      .clk     (clk),
      .rst_n   (rst_n),
      .req_val (req_val[i]),
      .req_rdy (req_rdy[i]),
      .req     (req[i]),
      .xw_val  (xw_val[i]),
      .xw_rdy  (xw_rdy[i]),
      .xw      (xw[i])
    );
  end

  writeback_commit_unit u_writeback_commit_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .xw_val       (xw_val),
    .xw_rdy       (xw_rdy),
    .xw           (xw),
    .complete_val (complete_val),
    .complete     (complete),
    .commit_val   (commit_val),
    .commit       (commit)
  );

endmodule

`default_nettype wire

// File: rtl/writeback_commit_unit.sv
/*
  Writeback-commit unit: fixed-priority pick among pipe results,
  completion strobe, reorder buffer and in-order commit
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module writeback_commit_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`WBC_NUM_PIPES-1:0]  xw_val,
  output logic [`WBC_NUM_PIPES-1:0]  xw_rdy,
  input  wbc_pkg::xw_msg_t           xw [`WBC_NUM_PIPES],
  output logic                       complete_val,
  output wbc_pkg::complete_msg_t     complete,
  output logic                       commit_val,
  output wbc_pkg::commit_msg_t       commit
);
  import wbc_pkg::*;

  localparam int DEPTH = `WBC_ROB_DEPTH;

  // Arbitration
  logic [`WBC_NUM_PIPES-1:0] grant;
  logic                      found;
  logic                      take;
  xw_msg_t                   sel_msg;

  // Reorder buffer, one slot per sequence number
  xw_msg_t                   rob_msg [DEPTH];
  logic [DEPTH-1:0]          rob_vld;
  seq_t                      head;
  logic                      head_ready;

  // ------------------------------------------------------------------
  // Pipe arbitration
  // ------------------------------------------------------------------

  // Lowest-indexed valid pipe gets the single write port
  always_comb begin
    grant   = '0;
    found   = 1'b0;
    sel_msg = xw[0];
    for (int i = 0; i < `WBC_NUM_PIPES; i++) begin
      if (xw_val[i] && !found) begin
        grant[i] = 1'b1;
        found    = 1'b1;
        sel_msg  = xw[i];
      end
    end
  end

  assign xw_rdy = grant;
  assign take   = found;

  // ------------------------------------------------------------------
  // Completion
  // ------------------------------------------------------------------

  // One pulse per accepted result, cycle after the transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      complete_val <= 1'b0;
    end else begin
      complete_val <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      complete.seq_num <= sel_msg.seq_num;
      complete.waddr   <= sel_msg.waddr;
      complete.wdata   <= sel_msg.wdata;
      complete.wen     <= sel_msg.wen;
    end
  end

  // ------------------------------------------------------------------
  // Reorder buffer
  // ------------------------------------------------------------------

  // Slot addressed by sequence number, so arrival order is irrelevant
  always_ff @(posedge clk) begin
    if (take) begin
      rob_msg[sel_msg.seq_num] <= sel_msg;
    end
  end

  // Head slot holds the oldest uncommitted instruction
  assign head_ready = rob_vld[head];

  // ------------------------------------------------------------------
  // In-order commit
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_vld    <= '0;
      head       <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;
      // Retire the head slot
      if (head_ready) begin
        rob_vld[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      // New result marks its slot; in-flight limit keeps it off the head being cleared
      if (take) begin
        rob_vld[sel_msg.seq_num] <= 1'b1;
      end
    end
  end

  // Commit payload registered with the strobe
  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit.pc      <= rob_msg[head].pc;
      commit.seq_num <= rob_msg[head].seq_num;
      commit.waddr   <= rob_msg[head].waddr;
      commit.wdata   <= rob_msg[head].wdata;
      commit.wen     <= rob_msg[head].wen;
    end
  end

endmodule

`default_nettype wire

// File: test/wbc_subsystem_properties.sv
/*
  Concurrent assertions on the writeback-commit unit,
  attached by bind
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module wbc_subsystem_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic [`WBC_NUM_PIPES-1:0] xw_rdy,
  input logic                      complete_val,
  input logic                      commit_val,
  input wbc_pkg::commit_msg_t      commit
);
  import wbc_pkg::*;

  // Seq of the previous commit, all ones so the first commit expects 0
  seq_t last_seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_seq <= '1;
    end else if (commit_val) begin
      last_seq <= commit.seq_num;
    end
  end

  // ------------------------------------------------------------------
  // Properties
  // ------------------------------------------------------------------

  // Strobes quiet while in reset
  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |-> (!complete_val && !commit_val))
    else $error("completion or commit strobe high during reset");

  // Commits walk the sequence space one step at a time
  a_commit_order: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> (commit.seq_num == seq_t'(last_seq + 1'b1)))
    else $error("commit sequence number skipped or repeated");

  // Single write port, one pipe granted at most
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(xw_rdy))
    else $error("more than one pipe granted in a cycle");

endmodule

bind writeback_commit_unit wbc_subsystem_properties u_wbc_subsystem_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .xw_rdy       (xw_rdy),
  .complete_val (complete_val),
  .commit_val   (commit_val),
  .commit       (commit)
);

`default_nettype wire

// File: test/wbc_subsystem_tb.sv
/*
  Testbench for the execute and writeback-commit subsystem with
  clock, reset, stimulus, reference model queue and checking
*/
`timescale 1ns/1ps
`default_nettype none
`include "wbc_settings.svh"

module wbc_subsystem_tb;
  import wbc_pkg::*;

  localparam int DEPTH      = `WBC_ROB_DEPTH;
  localparam int WAIT_LIMIT = 4000;

  logic          clk;
  logic          rst_n;
  logic          in_val;
  logic          in_rdy;
  instr_t        in_instr;
  logic          complete_val;
  complete_msg_t complete;
  logic          commit_val;
  commit_msg_t   commit;

  // Reference model queue in commit order plus per-seq expectations
  commit_msg_t exp_q [$];
  commit_msg_t exp_by_seq [DEPTH];
  logic        pend [DEPTH];
  int          age [DEPTH];
  seq_t        model_seq;
  int          accepted;
  int          completed;
  int          committed;
  int          errors;
  int          checks;
  int          tests_done;
  int          ooo_seen;
  int          newest_done;
  int          rdy_low_cycles;
  // Consecutive cycles an offered instruction was held off
  int          stall_run;
  integer      seed;

  always #5 clk = ~clk;

  wbc_subsystem u_wbc_subsystem (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .in_instr     (in_instr),
    .complete_val (complete_val),
    .complete     (complete),
    .commit_val   (commit_val),
    .commit       (commit)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("error t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic note_problem(input string what);
    $display("t=%0t %s", $time, what);
    errors++;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("t=%0t timeout: %s", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  function automatic instr_t make_instr(input op_e op, input logic [31:0] pc,
                                        input logic [4:0] waddr, input logic wen,
                                        input logic [31:0] a, input logic [31:0] b);
    instr_t ins;
    ins.pc    = pc;
    ins.op    = op;
    ins.waddr = waddr;
    ins.wen   = wen;
    ins.a     = a;
    ins.b     = b;
    return ins;
  endfunction

  // Called on a falling edge and returns on the one after the transfer
  task automatic send_instr(input instr_t ins);
    int n;
    n        = 0;
    in_val   = 1'b1;
    in_instr = ins;
    while (!in_rdy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!in_rdy) begin
      stop_on_timeout("in_rdy stayed low with an instruction waiting");
    end else begin
      @(negedge clk);
      in_val = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || completed != accepted) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0 || completed != accepted)
      stop_on_timeout("instructions never completed or committed");
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_done++;
    $display("test %0d %s: %0d errors", tests_done, name, errors - err_before);
  endtask

  // ------------------------------------------------------------------
  // Monitor and model sampled on the rising edge
  // ------------------------------------------------------------------

  always @(posedge clk) begin : monitor
    commit_msg_t exp;
    commit_msg_t head;
    if (!rst_n) begin
      assert (!complete_val && !commit_val) else note_problem("strobe high in reset");
    end else begin
      if (complete_val) begin
        exp = exp_by_seq[complete.seq_num];
        assert (pend[complete.seq_num]) else note_problem("completion with nothing pending");
        if (pend[complete.seq_num]) begin
          compare_value("complete.waddr", 32'(exp.waddr), 32'(complete.waddr));
          compare_value("complete.wdata", exp.wdata, complete.wdata);
          compare_value("complete.wen", 32'(exp.wen), 32'(complete.wen));
          pend[complete.seq_num] = 1'b0;
          completed++;
          // Older than something already done means out of program order
          if (age[complete.seq_num] < newest_done) ooo_seen++;
          else newest_done = age[complete.seq_num];
        end
      end
      if (commit_val) begin
        assert (exp_q.size() > 0) else note_problem("commit with empty model queue");
        if (exp_q.size() > 0) begin
          head = exp_q.pop_front();
          compare_value("commit.pc", head.pc, commit.pc);
          compare_value("commit.seq_num", 32'(head.seq_num), 32'(commit.seq_num));
          compare_value("commit.waddr", 32'(head.waddr), 32'(commit.waddr));
          compare_value("commit.wdata", head.wdata, commit.wdata);
          compare_value("commit.wen", 32'(head.wen), 32'(commit.wen));
          assert (!pend[head.seq_num]) else note_problem("commit before its completion");
          committed++;
        end
      end
      // Accepted instruction enters the model
      if (in_val && in_rdy) begin
        exp.pc      = in_instr.pc;
        exp.seq_num = model_seq;
        exp.waddr   = in_instr.waddr;
        exp.wen     = in_instr.wen;
        exp.wdata   = (in_instr.op == OP_MUL) ? in_instr.a * in_instr.b
                                              : in_instr.a + in_instr.b;
        exp_q.push_back(exp);
        exp_by_seq[model_seq] = exp;
        pend[model_seq]       = 1'b1;
        age[model_seq]        = accepted;
        accepted++;
        model_seq++;
      end
      // Dispatch register alone stalls one cycle, busy pipes stall longer
      if (in_val && !in_rdy) begin
        stall_run++;
        if (stall_run > 1) rdy_low_cycles++;
      end else begin
        stall_run = 0;
      end
      assert (accepted - committed <= DEPTH) else note_problem("in-flight count above depth");
    end
  end

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  initial begin : main
    instr_t      ins;
    logic [31:0] r;
    int          err0;
    clk = 1'b0;
    rst_n = 1'b0;
    in_val = 1'b0;
    in_instr = '0;
    model_seq = '0;
    accepted = 0;
    completed = 0;
    committed = 0;
    errors = 0;
    checks = 0;
    tests_done = 0;
    ooo_seen = 0;
    newest_done = -1;
    rdy_low_cycles = 0;
    stall_run = 0;
    seed = 85532;
    for (int i = 0; i < DEPTH; i++) begin
      pend[i] = 1'b0;
      age[i]  = 0;
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Ready high and strobes quiet after reset
    err0 = errors;
    repeat (6) begin
      @(negedge clk);
      assert (in_rdy && !complete_val && !commit_val) else note_problem("not idle after reset");
    end
    finish_test("reset", err0);

    err0 = errors;
    for (int i = 0; i < 10; i++) begin
      r = $random(seed);
      send_instr(make_instr(OP_ADD, 32'h1000 + i * 4, 5'(i + 1), 1'b1, r, 32'(i * 7)));
    end
    wait_drain();
    finish_test("in-order adds", err0);

    // Slow multiply ahead of fast adds
    err0 = errors;
    ooo_seen = 0;
    send_instr(make_instr(OP_MUL, 32'h2000, 5'd3, 1'b1, 32'h0001_2345, 32'h0000_0321));
    for (int i = 0; i < 4; i++) begin
      send_instr(make_instr(OP_ADD, 32'h2004 + i * 4, 5'(i + 8), 1'b1, 32'(i), 32'h10));
    end
    wait_drain();
    assert (ooo_seen > 0) else note_problem("no completion arrived out of program order");
    finish_test("reordering", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      ins = make_instr(op_e'(i % 2), 32'h3000 + i * 4, r[4:0], 1'b0, r, $random(seed));
      send_instr(ins);
    end
    wait_drain();
    finish_test("write enable low", err0);

    // Burst of more multiplies than the buffer holds
    err0 = errors;
    rdy_low_cycles = 0;
    for (int i = 0; i < DEPTH + 4; i++) begin
      send_instr(make_instr(OP_MUL, 32'h5000 + i * 4, 5'(i), 1'b1, $random(seed),
                            $random(seed)));
    end
    wait_drain();
    assert (rdy_low_cycles > 0) else note_problem("in_rdy never held low by busy pipes");
    finish_test("back-pressure", err0);

    err0 = errors;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      ins = make_instr(op_e'(r[0]), 32'h4000 + i * 4, r[5:1], r[6], $random(seed),
                       $random(seed));
      send_instr(ins);
      repeat (r[9:8]) @(negedge clk);
    end
    wait_drain();
    finish_test("random stream", err0);

    compare_value("committed count", 32'(accepted), 32'(committed));
    compare_value("completed count", 32'(accepted), 32'(completed));
    $display("tests %0d, instructions %0d, checks %0d, errors %0d",
             tests_done, accepted, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: wbc_subsystem.f
+incdir+rtl
rtl/wbc_pkg.sv
rtl/issue_dispatch.sv
rtl/exec_pipe.sv
rtl/writeback_commit_unit.sv
rtl/wbc_subsystem.sv
test/wbc_subsystem_properties.sv
test/wbc_subsystem_tb.sv
